//--- rtl/cache_settings.svh
// Data cache geometry
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// --------------------------------------------------
// bus widths
`define CACHE_ADDR_W      32
`define CACHE_DATA_W      64
`define CACHE_STRB_W      8

// --------------------------------------------------
// line and array shape, 4 KiB in two ways
`define CACHE_LINE_BYTES  32
`define CACHE_WORDS       4    // 64-bit words per line
`define CACHE_SETS        64
`define CACHE_WAYS        2

// address fields, addr = {tag, index, offset}
`define CACHE_OFFSET_W    5
`define CACHE_INDEX_W     6
`define CACHE_TAG_W       21

`define CACHE_LINE_W      (`CACHE_LINE_BYTES * 8)

`endif

//--- rtl/cache_pkg.sv
// Data cache shared types
`include "cache_settings.svh"

package cache_pkg;

  // --------------------------------------------------
  // address fields
  typedef logic [`CACHE_TAG_W-1:0]              tag_t;
  typedef logic [`CACHE_INDEX_W-1:0]            index_t;
  typedef logic [`CACHE_OFFSET_W-1:0]           offset_t;
  typedef logic [$clog2(`CACHE_WORDS)-1:0]      word_sel_t;  // offset[4:3]

  // --------------------------------------------------
  // data
  typedef logic [`CACHE_DATA_W-1:0]             word_t;
  typedef logic [`CACHE_STRB_W-1:0]             strb_t;
  typedef logic [`CACHE_LINE_W-1:0]             line_t;      // word 0 in the low bits
  typedef logic [`CACHE_WORDS-1:0]              word_en_t;

  typedef struct packed {
    tag_t tag;
    logic valid;
    logic dirty;  // line differs from memory
  } tag_entry_t;

  // controller states
  typedef enum logic [2:0] {
    IDLE       = 3'd0,
    LOOKUP     = 3'd1,
    WRITEBACK  = 3'd2,  // victim line out
    REFILL_REQ = 3'd3,  // line read request
    REFILL     = 3'd4   // beats coming back
  } miss_state_e;

endpackage

//--- rtl/cache_way_ram.sv
// Cache way storage
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_way_ram #(
  parameter type entry_t = cache_pkg::line_t,
  parameter int  WORDS   = 4
) (
  input  logic              i_clk,
  input  cache_pkg::index_t i_index,
  input  logic [WORDS-1:0]  i_wen,    // one enable per slice
  input  entry_t            i_wdata,
  output entry_t            o_rdata,
  input  logic              i_clr     // zero the entry at i_index
);

  localparam int ENTRY_W = $bits(entry_t);
  localparam int SLICE_W = ENTRY_W / WORDS;

  logic [ENTRY_W-1:0] mem [`CACHE_SETS];
  logic [ENTRY_W-1:0] wbits;

  assign wbits = i_wdata;

  always_ff @(posedge i_clk) begin
    if (i_clr) begin
      mem[i_index] <= '0;
    end else begin
      for (int w = 0; w < WORDS; w++) begin
        if (i_wen[w]) mem[i_index][w*SLICE_W +: SLICE_W] <= wbits[w*SLICE_W +: SLICE_W];
      end
    end
    o_rdata <= mem[i_index];  // read before write
  end

endmodule

//--- rtl/cache_req_stage.sv
// Cache request capture
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_req_stage (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  logic                 i_valid,
  input  logic                 i_op,          // 1 store, 0 load
  input  cache_pkg::tag_t      i_tag,
  input  cache_pkg::index_t    i_index,
  input  cache_pkg::offset_t   i_offset,
  input  cache_pkg::strb_t     i_wstrb,
  input  cache_pkg::word_t     i_wdata,
  input  logic                 i_ready,
  input  logic                 i_clr,         // reset sweep running
  input  cache_pkg::index_t    i_clr_index,
  output logic                 o_accept,
  output logic                 o_req_op,
  output cache_pkg::tag_t      o_req_tag,
  output cache_pkg::index_t    o_req_index,
  output cache_pkg::word_sel_t o_req_word,
  output cache_pkg::strb_t     o_req_strb,
  output cache_pkg::word_t     o_req_wdata,
  output cache_pkg::index_t    o_ram_index
);

  assign o_accept = i_valid && i_ready;

  always_ff @(posedge i_clk) begin
    if (i_rst) o_req_op <= 1'b0;
    else if (o_accept) o_req_op <= i_op;
    if (o_accept) begin
      o_req_tag   <= i_tag;
      o_req_index <= i_index;
      o_req_word  <= i_offset[`CACHE_OFFSET_W-1:3];  // byte offset inside word dropped
      o_req_strb  <= i_wstrb;
      o_req_wdata <= i_wdata;
    end
  end

  // RAMs see the new set in the accept cycle so LOOKUP has the read data
  assign o_ram_index = i_clr    ? i_clr_index :
                       o_accept ? i_index     : o_req_index;

endmodule

//--- rtl/cache_access_stage.sv
// Cache tag compare and array writes
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_access_stage (
  input  logic                  i_lookup,
  input  logic                  i_req_op,
  input  cache_pkg::tag_t       i_req_tag,
  input  cache_pkg::word_sel_t  i_req_word,
  input  cache_pkg::strb_t      i_req_strb,
  input  cache_pkg::word_t      i_req_wdata,
  input  cache_pkg::tag_entry_t i_tag_rd [`CACHE_WAYS],
  input  cache_pkg::line_t      i_line_rd [`CACHE_WAYS],
  input  logic                  i_fill_way,
  input  logic                  i_fill_wen,    // refill beat this cycle
  input  cache_pkg::word_sel_t  i_fill_word,
  input  cache_pkg::word_t      i_fill_data,
  input  logic                  i_fill_last,
  output logic                  o_hit,
  output cache_pkg::word_t      o_hit_rdata,
  output logic [`CACHE_WAYS-1:0] o_tag_wen,
  output cache_pkg::tag_entry_t o_tag_wdata,
  output cache_pkg::word_en_t   o_line_wen [`CACHE_WAYS],
  output cache_pkg::line_t      o_line_wdata
);

  logic [`CACHE_WAYS-1:0]   hit_way;
  logic [`CACHE_DATA_W-1:0] byte_mask;
  logic                     store_hit;
  logic                     merge;
  cache_pkg::word_sel_t     slot;
  cache_pkg::word_t         base_word;
  cache_pkg::word_t         new_word;

  // --------------------------------------------------
  // tag compare and load word select
  always_comb begin
    o_hit_rdata = '0;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      hit_way[w]   = i_tag_rd[w].valid && (i_tag_rd[w].tag == i_req_tag);
      o_hit_rdata |= {`CACHE_DATA_W{hit_way[w]}}
                   & i_line_rd[w][i_req_word*`CACHE_DATA_W +: `CACHE_DATA_W];
    end
    for (int b = 0; b < `CACHE_STRB_W; b++) begin
      byte_mask[b*8 +: 8] = {8{i_req_strb[b]}};
    end
  end

  assign o_hit     = |hit_way;
  assign store_hit = i_lookup && i_req_op && o_hit;

  // --------------------------------------------------
  // word to write, store bytes merged on a hit or on the request's beat
  assign merge     = i_fill_wen ? (i_req_op && (i_fill_word == i_req_word)) : store_hit;
  assign base_word = i_fill_wen ? i_fill_data : o_hit_rdata;
  assign new_word  = merge ? ((base_word & ~byte_mask) | (i_req_wdata & byte_mask)) : base_word;
  assign slot      = i_fill_wen ? i_fill_word : i_req_word;

  assign o_line_wdata = {`CACHE_WORDS{new_word}};  // slot picked by enables

  always_comb begin
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      o_line_wen[w] = ((store_hit && hit_way[w]) || (i_fill_wen && i_fill_way == w))
                    ? cache_pkg::word_en_t'(1) << slot : '0;
      o_tag_wen[w]  = (store_hit && hit_way[w])
                   || (i_fill_wen && i_fill_last && i_fill_way == w);
    end
  end

  // store hit sets dirty, a refill is dirty only for a store miss
  assign o_tag_wdata = '{tag: i_req_tag, valid: 1'b1, dirty: i_req_op};

endmodule

//--- rtl/cache_miss_ctrl.sv
// Cache miss controller
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_miss_ctrl (
  input  logic                     i_clk,
  input  logic                     i_rst,
  input  logic                     i_accept,
  input  logic                     i_hit,
  input  cache_pkg::word_t         i_hit_rdata,
  input  logic                     i_req_op,
  input  cache_pkg::tag_t          i_req_tag,
  input  cache_pkg::index_t        i_req_index,
  input  cache_pkg::word_sel_t     i_req_word,
  input  cache_pkg::tag_entry_t    i_tag_rd [`CACHE_WAYS],
  input  cache_pkg::line_t         i_line_rd [`CACHE_WAYS],
  input  logic                     i_rd_rdy,
  input  logic                     i_ret_valid,
  input  logic                     i_ret_last,
  input  cache_pkg::word_t         i_ret_data,
  input  logic                     i_wr_rdy,
  output logic                     o_ready,
  output logic                     o_lookup,
  output logic                     o_clr,
  output cache_pkg::index_t        o_clr_index,
  output logic                     o_fill_way,
  output logic                     o_fill_wen,
  output cache_pkg::word_sel_t     o_fill_word,
  output cache_pkg::word_t         o_fill_data,
  output logic                     o_fill_last,
  output logic                     o_addr_ok,
  output logic                     o_data_ok,
  output cache_pkg::word_t         o_rdata,
  output logic                     o_rd_req,
  output logic [`CACHE_ADDR_W-1:0] o_rd_addr,
  output logic                     o_wr_req,
  output logic [`CACHE_ADDR_W-1:0] o_wr_addr,
  output cache_pkg::line_t         o_wr_data
);

  cache_pkg::miss_state_e state_q;
  cache_pkg::word_sel_t   beat_q;     // refill beats seen
  logic                   victim_q;
  logic                   rr_q;       // round-robin pick when both valid
  logic                   sweep_q;
  cache_pkg::index_t      sweep_idx_q;
  logic                   vic_way;
  logic                   vic_dirty;

  // --------------------------------------------------
  // victim choice, invalid way first
  always_comb begin
    if (!i_tag_rd[0].valid) vic_way = 1'b0;
    else if (!i_tag_rd[1].valid) vic_way = 1'b1;
    else vic_way = rr_q;
  end
  assign vic_dirty = i_tag_rd[vic_way].valid && i_tag_rd[vic_way].dirty;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q     <= cache_pkg::IDLE;
      beat_q      <= '0;
      rr_q        <= 1'b0;
      sweep_q     <= 1'b1;
      sweep_idx_q <= '0;
    end else begin
      if (sweep_q) begin  // one set per cycle
        sweep_idx_q <= sweep_idx_q + 1'b1;
        if (sweep_idx_q == cache_pkg::index_t'(`CACHE_SETS - 1)) sweep_q <= 1'b0;
      end
      case (state_q)
        cache_pkg::IDLE:       if (i_accept) state_q <= cache_pkg::LOOKUP;
        cache_pkg::LOOKUP: begin
          if (i_hit) begin
            state_q <= cache_pkg::IDLE;
          end else begin
            victim_q <= vic_way;
            if (i_tag_rd[0].valid && i_tag_rd[1].valid) rr_q <= ~rr_q;
            state_q  <= vic_dirty ? cache_pkg::WRITEBACK : cache_pkg::REFILL_REQ;
          end
        end
        cache_pkg::WRITEBACK:  if (i_wr_rdy) state_q <= cache_pkg::REFILL_REQ;
        cache_pkg::REFILL_REQ: begin
          beat_q <= '0;
          if (i_rd_rdy) state_q <= cache_pkg::REFILL;
        end
        cache_pkg::REFILL: begin
          if (i_ret_valid) beat_q <= beat_q + 1'b1;  // gaps stall the count
          if (i_ret_valid && i_ret_last) state_q <= cache_pkg::IDLE;
        end
        default:               state_q <= cache_pkg::IDLE;
      endcase
    end
  end

  // --------------------------------------------------
  // stage controls
  assign o_ready     = (state_q == cache_pkg::IDLE) && !sweep_q;
  assign o_lookup    = state_q == cache_pkg::LOOKUP;
  assign o_clr       = sweep_q;
  assign o_clr_index = sweep_idx_q;
  assign o_fill_way  = victim_q;
  assign o_fill_wen  = (state_q == cache_pkg::REFILL) && i_ret_valid;
  assign o_fill_word = beat_q;
  assign o_fill_data = i_ret_data;
  assign o_fill_last = i_ret_last;

  // CPU side, critical word forwarded on its beat
  assign o_addr_ok = o_ready;
  assign o_data_ok = (o_lookup && i_hit) || (o_fill_wen && beat_q == i_req_word);
  assign o_rdata   = i_req_op ? '0 : (o_lookup ? i_hit_rdata : i_ret_data);  // loads only

  // memory side, whole lines
  assign o_rd_req  = state_q == cache_pkg::REFILL_REQ;
  assign o_rd_addr = {i_req_tag, i_req_index, {`CACHE_OFFSET_W{1'b0}}};
  assign o_wr_req  = state_q == cache_pkg::WRITEBACK;
  assign o_wr_addr = {i_tag_rd[victim_q].tag, i_req_index, {`CACHE_OFFSET_W{1'b0}}};
  assign o_wr_data = i_line_rd[victim_q];  // arrays hold the set during write-back

endmodule

//--- rtl/cache_top.sv
// Two-way data cache
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_top (
  input  logic                     i_clk,
  input  logic                     i_rst,

  // CPU side
  input  logic                     i_valid,
  input  logic                     i_op,        // 1 store, 0 load
  input  cache_pkg::index_t        i_index,
  input  cache_pkg::tag_t          i_tag,
  input  cache_pkg::offset_t       i_offset,
  input  cache_pkg::strb_t         i_wstrb,
  input  cache_pkg::word_t         i_wdata,
  output logic                     o_addr_ok,
  output logic                     o_data_ok,
  output cache_pkg::word_t         o_rdata,

  // memory side
  output logic                     o_rd_req,
  output logic [`CACHE_ADDR_W-1:0] o_rd_addr,
  input  logic                     i_rd_rdy,
  input  logic                     i_ret_valid,
  input  logic                     i_ret_last,
  input  cache_pkg::word_t         i_ret_data,
  output logic                     o_wr_req,
  output logic [`CACHE_ADDR_W-1:0] o_wr_addr,
  output cache_pkg::line_t         o_wr_data,
  input  logic                     i_wr_rdy
);

  // --------------------------------------------------
  // stage wiring
  logic                   accept;
  logic                   ready;
  logic                   lookup;
  logic                   clr;
  cache_pkg::index_t      clr_index;
  logic                   req_op;
  cache_pkg::tag_t        req_tag;
  cache_pkg::index_t      req_index;
  cache_pkg::word_sel_t   req_word;
  cache_pkg::strb_t       req_strb;
  cache_pkg::word_t       req_wdata;
  cache_pkg::index_t      ram_index;
  logic                   hit;
  cache_pkg::word_t       hit_rdata;
  logic                   fill_way;
  logic                   fill_wen;
  cache_pkg::word_sel_t   fill_word;
  cache_pkg::word_t       fill_data;
  logic                   fill_last;

  // array ports
  cache_pkg::tag_entry_t  tag_rd [`CACHE_WAYS];
  cache_pkg::line_t       line_rd [`CACHE_WAYS];
  logic [`CACHE_WAYS-1:0] tag_wen;
  cache_pkg::tag_entry_t  tag_wdata;
  cache_pkg::word_en_t    line_wen [`CACHE_WAYS];
  cache_pkg::line_t       line_wdata;

  cache_req_stage u_req (
    .i_clk, .i_rst, .i_valid, .i_op, .i_tag, .i_index, .i_offset, .i_wstrb, .i_wdata,
    .i_ready(ready), .i_clr(clr), .i_clr_index(clr_index), .o_accept(accept),
    .o_req_op(req_op), .o_req_tag(req_tag), .o_req_index(req_index), .o_req_word(req_word),
    .o_req_strb(req_strb), .o_req_wdata(req_wdata), .o_ram_index(ram_index)
  );

  cache_access_stage u_access (
    .i_lookup(lookup), .i_req_op(req_op), .i_req_tag(req_tag), .i_req_word(req_word),
    .i_req_strb(req_strb), .i_req_wdata(req_wdata), .i_tag_rd(tag_rd), .i_line_rd(line_rd),
    .i_fill_way(fill_way), .i_fill_wen(fill_wen), .i_fill_word(fill_word),
    .i_fill_data(fill_data), .i_fill_last(fill_last), .o_hit(hit), .o_hit_rdata(hit_rdata),
    .o_tag_wen(tag_wen), .o_tag_wdata(tag_wdata), .o_line_wen(line_wen),
    .o_line_wdata(line_wdata)
  );

  // tag copy and data copy per way
  for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
    cache_way_ram #(.entry_t(cache_pkg::tag_entry_t), .WORDS(1)) u_tag_ram (
      .i_clk, .i_index(ram_index), .i_wen(tag_wen[w]), .i_wdata(tag_wdata),
      .o_rdata(tag_rd[w]), .i_clr(clr)
    );
    cache_way_ram #(.entry_t(cache_pkg::line_t), .WORDS(`CACHE_WORDS)) u_data_ram (
      .i_clk, .i_index(ram_index), .i_wen(line_wen[w]), .i_wdata(line_wdata),
      .o_rdata(line_rd[w]), .i_clr(1'b0)  // data needs no sweep
    );
  end

  cache_miss_ctrl u_ctrl (
    .i_clk, .i_rst, .i_accept(accept), .i_hit(hit), .i_hit_rdata(hit_rdata),
    .i_req_op(req_op), .i_req_tag(req_tag), .i_req_index(req_index), .i_req_word(req_word),
    .i_tag_rd(tag_rd), .i_line_rd(line_rd), .i_rd_rdy, .i_ret_valid, .i_ret_last,
    .i_ret_data, .i_wr_rdy, .o_ready(ready), .o_lookup(lookup), .o_clr(clr),
    .o_clr_index(clr_index), .o_fill_way(fill_way), .o_fill_wen(fill_wen),
    .o_fill_word(fill_word), .o_fill_data(fill_data), .o_fill_last(fill_last),
    .o_addr_ok, .o_data_ok, .o_rdata, .o_rd_req, .o_rd_addr, .o_wr_req, .o_wr_addr,
    .o_wr_data
  );

endmodule

//--- bench/cache_tests.svh
// Directed cache tests

// --------------------------------------------------
// single line, set 9, word 1
task automatic test_cold_load();
  run_access(1'b0, 32'h0000_0128, '0, '0);
endtask

task automatic test_load_hit();
  run_access(1'b0, 32'h0000_0128, '0, '0);  // one cycle, no line read
endtask

task automatic test_store_hit();
  run_access(1'b1, 32'h0000_0128, 8'b0011_0101, {next_rand(), next_rand()});
  run_access(1'b0, 32'h0000_0128, '0, '0);
endtask

// store on a miss merges into beat 2, rest of the line from memory
task automatic test_store_miss();
  run_access(1'b1, 32'h0000_0470, 8'hf0, {next_rand(), next_rand()});
  run_access(1'b0, 32'h0000_0470, '0, '0);
  run_access(1'b0, 32'h0000_0460, '0, '0);
endtask

// --------------------------------------------------
// tags 1, 2 and 3 all in set 0x11
task automatic test_dirty_evict();
  run_access(1'b1, 32'h0000_0a28, 8'hff, {next_rand(), next_rand()});  // way 0
  run_access(1'b1, 32'h0000_1230, 8'h0f, {next_rand(), next_rand()});  // way 1
  run_access(1'b0, 32'h0000_1a20, '0, '0);                               // dirty victim
  run_access(1'b0, 32'h0000_0a28, '0, '0);
  run_access(1'b0, 32'h0000_1230, '0, '0);
  run_access(1'b1, 32'h0000_1a38, 8'h81, {next_rand(), next_rand()});
endtask

// random ops over four tags and sets 0x30 to 0x33
task automatic test_back_pressure();
  logic [31:0] r;
  rand_stall = 1'b1;
  for (int i = 0; i < 16; i++) begin
    r = next_rand();
    run_access(r[0], {19'b0, r[9:8], 4'b1100, r[2:1], r[4:3], 3'b0}, r[19:12],
               {next_rand(), next_rand()});
  end
  rand_stall = 1'b0;
endtask

//--- bench/cache_tb.sv
// Data cache testbench
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_tb;

  localparam int RESET_CYCLES = 16;
  localparam int NUM_REQS     = 29;    // requests issued over all tests
  localparam int MAX_CYCLES   = RESET_CYCLES + `CACHE_SETS + 40 * NUM_REQS;
  localparam int MEM_WORDS    = 4096;  // 32 KiB, tags 0 to 15

  logic                     i_clk, i_rst, i_valid, i_op;
  cache_pkg::index_t        i_index;
  cache_pkg::tag_t          i_tag;
  cache_pkg::offset_t       i_offset;
  cache_pkg::strb_t         i_wstrb;
  cache_pkg::word_t         i_wdata, o_rdata, i_ret_data;
  logic                     o_addr_ok, o_data_ok, o_rd_req, o_wr_req;
  logic                     i_rd_rdy, i_ret_valid, i_ret_last, i_wr_rdy;
  logic [`CACHE_ADDR_W-1:0] o_rd_addr, o_wr_addr, rd_addr_q, wr_addr_q;
  cache_pkg::line_t         o_wr_data, wr_data_q;

  cache_pkg::word_t mem [MEM_WORDS];
  logic [31:0]      rng_state;
  logic             rand_stall;  // random back-pressure and beat gaps
  int               rd_count, wr_count, cycles;

  // --------------------------------------------------
  // reference model of the tag and data arrays
  cache_pkg::tag_t  ref_tag   [`CACHE_SETS][`CACHE_WAYS];
  logic             ref_valid [`CACHE_SETS][`CACHE_WAYS];
  logic             ref_dirty [`CACHE_SETS][`CACHE_WAYS];
  cache_pkg::line_t ref_line  [`CACHE_SETS][`CACHE_WAYS];
  logic             ref_rr;      // one bit for all sets

  cache_top i_cache_top (.*);

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) report_error("timeout, the tests did not finish in time");
  end

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input cache_pkg::word_t got,
                            input cache_pkg::word_t want);
    if (got !== want) report_error($sformatf("MISMATCH %s got %h expected %h", name, got, want));
  endtask

  task automatic check_line(input string name, input cache_pkg::line_t got,
                            input cache_pkg::line_t want);
    if (got !== want) report_error($sformatf("MISMATCH %s got %h expected %h", name, got, want));
  endtask

  task automatic check_addr(input string name, input logic [`CACHE_ADDR_W-1:0] got,
                            input logic [`CACHE_ADDR_W-1:0] want);
    if (got !== want) report_error($sformatf("MISMATCH %s got %h expected %h", name, got, want));
  endtask

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic int stall_cycles();
    return rand_stall ? int'(next_rand() % 4) : 2;
  endfunction

  function automatic cache_pkg::word_t merge_bytes(input cache_pkg::word_t old_w,
                                                   input cache_pkg::word_t new_w,
                                                   input cache_pkg::strb_t strb);
    cache_pkg::word_t res;
    res = old_w;
    for (int b = 0; b < `CACHE_STRB_W; b++) begin
      if (strb[b]) res[b*8 +: 8] = new_w[b*8 +: 8];
    end
    return res;
  endfunction

  // --------------------------------------------------
  // memory side, one line transfer at a time
  task automatic serve_write();
    logic [`CACHE_ADDR_W-1:0] a;
    cache_pkg::line_t         d;
    a = o_wr_addr;
    d = o_wr_data;
    repeat (stall_cycles()) begin
      @(negedge i_clk);
      if (o_wr_req !== 1'b1) report_error("o_wr_req dropped before i_wr_rdy");
      check_addr("o_wr_addr", o_wr_addr, a);
      check_line("o_wr_data", o_wr_data, d);
    end
    @(posedge i_clk);
    #10 i_wr_rdy = 1'b1;
    @(posedge i_clk);       // line taken here
    #10 i_wr_rdy = 1'b0;
    for (int b = 0; b < `CACHE_WORDS; b++) begin
      mem[int'(a[14:3]) + b] = d[b*`CACHE_DATA_W +: `CACHE_DATA_W];
    end
    wr_count++;
    wr_addr_q = a;
    wr_data_q = d;
  endtask

  task automatic serve_read();
    logic [`CACHE_ADDR_W-1:0] a;
    a = o_rd_addr;
    repeat (stall_cycles()) begin
      @(negedge i_clk);
      if (o_rd_req !== 1'b1) report_error("o_rd_req dropped before i_rd_rdy");
      check_addr("o_rd_addr", o_rd_addr, a);
    end
    @(posedge i_clk);
    #10 i_rd_rdy = 1'b1;
    @(posedge i_clk);
    #10 i_rd_rdy = 1'b0;
    rd_count++;
    rd_addr_q = a;
    for (int b = 0; b < `CACHE_WORDS; b++) begin
      i_ret_valid = 1'b0;
      repeat (rand_stall ? int'(next_rand() % 3) : 0) begin  // gap before the beat
        @(posedge i_clk);
        #10;
      end
      i_ret_valid = 1'b1;
      i_ret_last  = (b == `CACHE_WORDS - 1);
      i_ret_data  = mem[int'(a[14:3]) + b];
      @(posedge i_clk);
      #10;
    end
    i_ret_valid = 1'b0;
    i_ret_last  = 1'b0;
  endtask

  initial begin
    forever begin
      @(negedge i_clk);
      if (o_wr_req === 1'b1) serve_write();
      else if (o_rd_req === 1'b1) serve_read();
    end
  end

  // --------------------------------------------------
  // CPU side
  task automatic do_request(input logic op, input logic [`CACHE_ADDR_W-1:0] addr,
                            input cache_pkg::strb_t strb, input cache_pkg::word_t wdata,
                            output cache_pkg::word_t rdata, output int lat);
    @(posedge i_clk);
    #10;
    i_valid = 1'b1;
    i_op    = op;
    {i_tag, i_index, i_offset} = addr;
    i_wstrb = strb;
    i_wdata = wdata;
    do @(negedge i_clk); while (o_addr_ok !== 1'b1);
    @(posedge i_clk);       // accepted here
    #10 i_valid = 1'b0;
    lat = 0;
    do begin
      @(negedge i_clk);
      lat++;
    end while (o_data_ok !== 1'b1);
    rdata = o_rdata;
    while (o_addr_ok !== 1'b1) @(negedge i_clk);
  endtask

  task automatic run_access(input logic op, input logic [`CACHE_ADDR_W-1:0] addr,
                            input cache_pkg::strb_t strb, input cache_pkg::word_t wdata);
    cache_pkg::index_t        idx;
    cache_pkg::tag_t          tag;
    cache_pkg::word_sel_t     ws;
    cache_pkg::word_t         want, got;
    cache_pkg::line_t         fill, wb_line;
    logic [`CACHE_ADDR_W-1:0] wb_addr;
    logic                     hit, wb;
    int                       way, lat, rd0, wr0;
    {tag, idx} = addr[`CACHE_ADDR_W-1:`CACHE_OFFSET_W];
    ws  = addr[4:3];
    way = 0;
    hit = 1'b0;
    wb  = 1'b0;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (ref_valid[idx][w] && ref_tag[idx][w] == tag) begin
        hit = 1'b1;
        way = w;
      end
    end
    if (!hit) begin
      // invalid way first, else the round-robin bit, which then flips
      if (!ref_valid[idx][0]) way = 0;
      else if (!ref_valid[idx][1]) way = 1;
      else begin
        way    = ref_rr;
        ref_rr = ~ref_rr;
      end
      wb      = ref_valid[idx][way] && ref_dirty[idx][way];
      wb_addr = {ref_tag[idx][way], idx, 5'b0};
      wb_line = ref_line[idx][way];
      for (int b = 0; b < `CACHE_WORDS; b++) begin
        fill[b*`CACHE_DATA_W +: `CACHE_DATA_W] = mem[int'({addr[14:5], 2'b00}) + b];
      end
      ref_line[idx][way]  = fill;
      ref_tag[idx][way]   = tag;
      ref_valid[idx][way] = 1'b1;
      ref_dirty[idx][way] = 1'b0;
    end
    want = ref_line[idx][way][ws*`CACHE_DATA_W +: `CACHE_DATA_W];
    if (op) begin
      ref_line[idx][way][ws*`CACHE_DATA_W +: `CACHE_DATA_W] = merge_bytes(want, wdata, strb);
      ref_dirty[idx][way] = 1'b1;
    end
    rd0 = rd_count;
    wr0 = wr_count;
    do_request(op, addr, strb, wdata, got, lat);
    if (!op) check_word("o_rdata", got, want);
    if (hit) begin
      if (lat != 1) report_error($sformatf("hit answered after %0d cycles instead of 1", lat));
      if (rd_count != rd0) report_error("line read issued on a hit");
    end else begin
      if (rd_count != rd0 + 1) report_error("no line read on a miss");
      check_addr("o_rd_addr", rd_addr_q, {addr[`CACHE_ADDR_W-1:5], 5'b0});
    end
    if (wb) begin
      if (wr_count != wr0 + 1) report_error("dirty victim was not written back");
      check_addr("o_wr_addr", wr_addr_q, wb_addr);
      check_line("o_wr_data", wr_data_q, wb_line);
    end else if (wr_count != wr0) begin
      report_error("line written back without a dirty victim");
    end
  endtask

  `include "cache_tests.svh"

  initial begin
    rng_state  = 32'd62;
    rand_stall = 1'b0;
    rd_count   = 0;
    wr_count   = 0;
    cycles     = 0;
    i_rst      = 1'b1;
    i_valid    = 1'b0;
    i_op       = 1'b0;
    {i_tag, i_index, i_offset} = '0;
    i_wstrb     = '0;
    i_wdata     = '0;
    i_rd_rdy    = 1'b0;
    i_ret_valid = 1'b0;
    i_ret_last  = 1'b0;
    i_ret_data  = '0;
    i_wr_rdy    = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = {next_rand(), 32'(i * 8)};  // low half is the byte address
    end
    for (int s = 0; s < `CACHE_SETS; s++) begin
      for (int w = 0; w < `CACHE_WAYS; w++) begin
        ref_valid[s][w] = 1'b0;
        ref_dirty[s][w] = 1'b0;
      end
    end
    ref_rr = 1'b0;
    repeat (RESET_CYCLES) @(posedge i_clk);
    #10 i_rst = 1'b0;
    do @(negedge i_clk); while (o_addr_ok !== 1'b1);  // tag sweep
    test_cold_load();
    test_load_hit();
    test_store_hit();
    test_store_miss();
    test_dirty_evict();
    test_back_pressure();
    $display("Done: no errors");
    $finish;
  end

endmodule

//--- src.f
+incdir+rtl
+incdir+bench
rtl/cache_pkg.sv
rtl/cache_way_ram.sv
rtl/cache_req_stage.sv
rtl/cache_access_stage.sv
rtl/cache_miss_ctrl.sv
rtl/cache_top.sv
bench/cache_tb.sv

//--- Bender.yml
package:
  name: cache_dcache

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/cache_pkg.sv
      - rtl/cache_way_ram.sv
      - rtl/cache_req_stage.sv
      - rtl/cache_access_stage.sv
      - rtl/cache_miss_ctrl.sv
      - rtl/cache_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/cache_tb.sv
